// ==== Bender.yml ====
package:
  name: play_mode

sources:
  - verilog/game_pkg.sv
  - verilog/hit_capture.sv
  - verilog/tone_player.sv
  - verilog/song_rom.sv
  - verilog/hit_scorer.sv
  - verilog/play_mode.sv
  - target: test
    files:
      - verification/play_mode_tb.sv

// ==== verification/play_mode_tb.sv ====
module play_mode_tb import game_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int HITS         = 23;                // Both passes of song 0, song 1 and a wrap
    localparam int LONGEST_TONE = BEAT_CYCLES * 8;   // Whole note
    localparam int GRADE_LIMIT  = LONGEST_TONE + 100;
    localparam int WATCHDOG     = HITS * (LONGEST_TONE + 300) * CLK_PERIOD + 10000;

    typedef struct packed {
        grade_t     grade;
        logic [3:0] combo;
        logic [7:0] points;
    } result_t;

    typedef struct packed {
        grade_t                grade;
        logic [SCORE_BITS-1:0] score;
        logic [COMBO_BITS-1:0] combo;
        logic                  last;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic [SONG_BITS-1:0]   song;
    logic [NOTE_KEYS-1:0]   note_key;
    logic [LENGTH_KEYS-1:0] length_key;
    logic                   oct_up;
    logic                   oct_down;
    logic                   hit;
    logic [NOTE_KEYS-1:0]   note_led;
    logic                   buzzer;
    logic [SCORE_BITS-1:0]  score;
    logic [COMBO_BITS-1:0]  combo;
    grade_t                 grade;
    logic                   grade_valid;
    logic                   song_done;

    int      seed        = 19;
    string   test_name   = "reset";
    octave_t tb_octave   = OCT_MID;
    int      tb_song     = 0;
    int      tb_step     = 0;
    int      exp_score   = 0;
    int      exp_combo   = 0;
    int      exp_half    = 0;       // Zero while a rest plays
    int      pushed      = 0;
    int      grades_seen = 0;
    int      cycle       = 0;
    int      last_edge   = -1;
    logic    buzzer_q    = 1'b0;
    logic    en_q        = 1'b0;
    expect_t pending [$];

    tone_t song_0 [8] = '{
        '{OCT_MID, NOTE_C, LEN_QUARTER}, '{OCT_MID, NOTE_D, LEN_EIGHTH},
        '{OCT_MID, NOTE_E, LEN_QUARTER}, '{OCT_MID, NOTE_C, LEN_EIGHTH},
        '{OCT_LOW, NOTE_G, LEN_QUARTER}, '{OCT_MID, NOTE_F, LEN_EIGHTH},
        '{OCT_HIGH, NOTE_C, LEN_QUARTER}, '{OCT_MID, NOTE_G, LEN_HALF}
    };
    tone_t song_1 [6] = '{
        '{OCT_LOW, NOTE_A, LEN_EIGHTH}, '{OCT_MID, NOTE_B, LEN_QUARTER},
        '{OCT_MID, NOTE_REST, LEN_EIGHTH}, '{OCT_HIGH, NOTE_E, LEN_EIGHTH},
        '{OCT_HIGH, NOTE_D, LEN_QUARTER}, '{OCT_MID, NOTE_A, LEN_WHOLE}
    };
    int base_half [8] = '{0, 48, 43, 38, 36, 32, 28, 25};  // Low octave values with the rest first

    play_mode play_mode_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        en_q  <= en;
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic tone_t goal_tone(input int s, input int st);
        return (s == 0) ? song_0[st] : song_1[st];
    endfunction

    function automatic logic [NOTE_KEYS-1:0] expected_leds(input int s, input int st);
        tone_t g;
        g = goal_tone(s, st);
        if (g.note == NOTE_REST) return '0;
        else return NOTE_KEYS'(1) << (int'(g.note) - 1);
    endfunction

    function automatic result_t expected_grade(input int s, input int st, input tone_t struck,
                                               input int wait_cycles, input int combo_now);
        tone_t   goal;
        result_t r;
        goal = goal_tone(s, st);
        if (struck.note != goal.note || struck.octave != goal.octave) begin
            r = '{GRADE_MISS, 4'd0, 8'd0};
        end else begin
            if (struck.length != goal.length || wait_cycles >= REACT_FAST) r.grade = GRADE_GOOD;
            else r.grade = GRADE_PERFECT;
            r.combo  = (combo_now >= 15) ? 4'd15 : 4'(combo_now + 1);
            r.points = 8'(((r.grade == GRADE_PERFECT) ? POINTS_PERFECT : POINTS_GOOD) + r.combo);
        end
        return r;
    endfunction

    // Wanted key plus random higher keys that must not win
    function automatic logic [NOTE_KEYS-1:0] key_levels(input int pos);
        logic [NOTE_KEYS-1:0] one;
        logic [NOTE_KEYS-1:0] extra;
        one   = NOTE_KEYS'(1) << pos;
        extra = NOTE_KEYS'($random(seed));
        return one | (extra & ~((one << 1) - NOTE_KEYS'(1)));
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            stop_run($sformatf("MISMATCH %s %s expected %0d actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    // ########################################################################
    // Stimulus tasks
    // ########################################################################

    task automatic pulse_octave(input bit up, input int times);
        repeat (times) begin
            oct_up   = up;
            oct_down = !up;
            @(negedge clk);
            oct_up   = 1'b0;
            oct_down = 1'b0;
            @(negedge clk);
            if (up && tb_octave != OCT_HIGH) tb_octave = octave_t'(tb_octave + 1);
            else if (!up && tb_octave != OCT_LOW) tb_octave = octave_t'(tb_octave - 1);
        end
    endtask

    task automatic wait_grade();
        int n;
        n = 0;
        while (grades_seen < pushed && n < GRADE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (grades_seen < pushed) stop_run("No grade_valid pulse came after an accepted hit");
        else @(negedge clk);
    endtask

    task automatic play_step(input note_t n, input length_t len, input int wait_cycles,
                             input bit busy_hit);
        tone_t   struck;
        result_t r;
        expect_t e;
        repeat (wait_cycles) @(negedge clk);
        struck     = '{tb_octave, n, len};
        note_key   = (n == NOTE_REST) ? '0 : key_levels(int'(n) - 1);
        length_key = LENGTH_KEYS'(key_levels(int'(len)));
        exp_half   = base_half[int'(n)] >> int'(tb_octave);
        hit        = 1'b1;
        @(negedge clk);
        hit = 1'b0;
        r = expected_grade(tb_song, tb_step, struck, wait_cycles, exp_combo);
        exp_combo = r.combo;
        exp_score = exp_score + r.points;
        e = '{r.grade, SCORE_BITS'(exp_score), r.combo, tb_step == ((tb_song == 0) ? 7 : 5)};
        pending.push_back(e);
        pushed++;
        if (busy_hit) begin
            repeat (20) @(negedge clk);  // Tone still sounding
            note_key   = key_levels(0);
            length_key = '1;
            hit        = 1'b1;
            @(negedge clk);
            hit = 1'b0;
        end
        wait_grade();
    endtask

    // ########################################################################
    // Compare process
    // ########################################################################

    task automatic compare_grade();
        expect_t e;
        if (pending.size() == 0) begin
            stop_run("A grade_valid pulse came with no accepted hit pending");
        end else begin
            e = pending.pop_front();
            check("grade", int'(e.grade), int'(grade));
            check("score", e.score, score);
            check("combo", e.combo, combo);
            check("song_done", e.last, song_done);
            grades_seen++;
            tb_step   = e.last ? 0 : tb_step + 1;
            last_edge = -1;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (buzzer !== buzzer_q && !grade_valid) begin  // Final drop at done not counted
                if (last_edge >= 0) check("buzzer half-period", exp_half, cycle - last_edge);
                last_edge = cycle;
            end
            buzzer_q = buzzer;
            if (exp_half == 0) check("buzzer during rest", 0, buzzer);
            if (grade_valid) compare_grade();
            else check("song_done without grade", 0, song_done);
            if (en && en_q) check("note_led", expected_leds(tb_song, tb_step), note_led);
        end
    end

    initial begin
        #(WATCHDOG);
        stop_run("Timeout, the tests did not finish within the expected time");
    end

    initial begin
        rst_n      = 1'b0;
        en         = 1'b0;
        song       = '0;
        note_key   = '0;
        length_key = '0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        hit        = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("score", 0, score);
        check("combo", 0, combo);
        check("grade_valid", 0, grade_valid);
        check("buzzer", 0, buzzer);
        en = 1'b1;

        test_name = "perfect_song_0";
        play_step(NOTE_C, LEN_QUARTER, 5, 0);
        play_step(NOTE_D, LEN_EIGHTH, 5, 1);
        play_step(NOTE_E, LEN_QUARTER, 5, 0);
        play_step(NOTE_C, LEN_EIGHTH, 5, 0);
        pulse_octave(0, 3);                      // Saturates at LOW
        play_step(NOTE_G, LEN_QUARTER, 5, 0);
        pulse_octave(1, 1);
        play_step(NOTE_F, LEN_EIGHTH, 5, 0);
        pulse_octave(1, 3);                      // Saturates at HIGH
        play_step(NOTE_C, LEN_QUARTER, 5, 0);
        pulse_octave(0, 1);
        play_step(NOTE_G, LEN_HALF, 5, 0);

        test_name = "grading_rules";
        play_step(NOTE_D, LEN_QUARTER, 5, 0);    // Wrong note
        pulse_octave(1, 1);
        play_step(NOTE_D, LEN_EIGHTH, 5, 0);     // Wrong octave
        pulse_octave(0, 1);
        play_step(NOTE_E, LEN_EIGHTH, 5, 0);     // Wrong length
        play_step(NOTE_C, LEN_EIGHTH, 250, 0);   // Slow
        pulse_octave(0, 1);
        play_step(NOTE_G, LEN_QUARTER, 5, 0);
        pulse_octave(1, 1);
        play_step(NOTE_REST, LEN_EIGHTH, 5, 0);
        pulse_octave(1, 1);
        play_step(NOTE_C, LEN_QUARTER, 5, 1);
        pulse_octave(0, 1);
        play_step(NOTE_G, LEN_WHOLE, 5, 0);

        test_name = "song_1_wrap";
        en   = 1'b0;
        song = 1'b1;
        repeat (2) @(negedge clk);
        check("score with en low", 0, score);
        check("combo with en low", 0, combo);
        tb_song   = 1;
        tb_step   = 0;
        exp_score = 0;
        exp_combo = 0;
        @(negedge clk);
        en = 1'b1;
        pulse_octave(0, 1);
        play_step(NOTE_A, LEN_EIGHTH, 5, 0);
        pulse_octave(1, 1);
        play_step(NOTE_B, LEN_QUARTER, 5, 0);
        play_step(NOTE_REST, LEN_EIGHTH, 5, 0);
        pulse_octave(1, 1);
        play_step(NOTE_E, LEN_EIGHTH, 5, 0);
        play_step(NOTE_D, LEN_QUARTER, 250, 0);
        pulse_octave(0, 1);
        play_step(NOTE_A, LEN_WHOLE, 5, 0);
        pulse_octave(0, 1);
        play_step(NOTE_A, LEN_EIGHTH, 5, 0);     // First step again after the wrap

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

    // ########################################################################
    // Sizes
    // ########################################################################

    localparam int NOTE_KEYS   = 7;
    localparam int LENGTH_KEYS = 4;
    localparam int TICK_BITS   = 16;
    localparam int STEP_BITS   = 4;
    localparam int SONG_BITS   = 1;   // Two songs
    localparam int SCORE_BITS  = 16;
    localparam int COMBO_BITS  = 4;   // Saturates at 15
    localparam int HALF_BITS   = 6;   // Widest half-period is 48
    localparam int DUR_BITS    = 10;  // Whole note is 512 cycles

    // ########################################################################
    // Timing and scoring
    // ########################################################################

    localparam int BEAT_CYCLES    = 64;   // Eighth note, doubled per length step
    localparam int REACT_FAST     = 100;  // Ticks allowed for a PERFECT
    localparam int POINTS_PERFECT = 10;
    localparam int POINTS_GOOD    = 5;

    typedef enum logic [2:0] {
        NOTE_REST,
        NOTE_C,
        NOTE_D,
        NOTE_E,
        NOTE_F,
        NOTE_G,
        NOTE_A,
        NOTE_B
    } note_t;

    typedef enum logic [1:0] {
        OCT_LOW,
        OCT_MID,
        OCT_HIGH
    } octave_t;

    typedef enum logic [1:0] {
        LEN_EIGHTH,
        LEN_QUARTER,
        LEN_HALF,
        LEN_WHOLE
    } length_t;

    typedef enum logic [1:0] {
        GRADE_MISS,
        GRADE_GOOD,
        GRADE_PERFECT
    } grade_t;

    typedef struct packed {
        octave_t octave;
        note_t   note;
        length_t length;
    } tone_t;

    typedef struct packed {
        tone_t                tone;
        logic [TICK_BITS-1:0] stamp;  // Tick of the strike
    } hit_t;

    // Half-period in cycles, zero for a rest
    function automatic logic [HALF_BITS-1:0] tone_half_period(octave_t octave, note_t note);
        logic [HALF_BITS-1:0] base;
        case (note)
            NOTE_C:  base = 6'd48;
            NOTE_D:  base = 6'd43;
            NOTE_E:  base = 6'd38;
            NOTE_F:  base = 6'd36;
            NOTE_G:  base = 6'd32;
            NOTE_A:  base = 6'd28;
            NOTE_B:  base = 6'd25;
            default: base = 6'd0;
        endcase
        return base >> octave;  // Halved per octave above LOW
    endfunction

endpackage

// ==== verilog/hit_capture.sv ====
module hit_capture import game_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic                   oct_up,
    input  logic                   oct_down,
    input  logic [NOTE_KEYS-1:0]   note_key,
    input  logic [LENGTH_KEYS-1:0] length_key,
    input  logic                   strike,
    input  logic [TICK_BITS-1:0]   tick,
    output hit_t                   cap,
    output logic                   cap_valid
);

    octave_t octave;
    note_t   key_note;
    length_t key_length;

    // Saturating octave select
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            octave <= OCT_MID;
        end else if (en) begin
            if (oct_up && !oct_down && octave != OCT_HIGH) begin
                octave <= octave_t'(octave + 2'd1);
            end else if (oct_down && !oct_up && octave != OCT_LOW) begin
                octave <= octave_t'(octave - 2'd1);
            end
        end
    end

    // Lowest pressed key wins
    always_comb begin
        key_note = NOTE_REST;
        for (int i = NOTE_KEYS - 1; i >= 0; i--) begin
            if (note_key[i]) key_note = note_t'(i + 1);
        end
    end

    always_comb begin
        key_length = LEN_EIGHTH;
        for (int k = LENGTH_KEYS - 1; k >= 0; k--) begin
            if (length_key[k]) key_length = length_t'(k);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= strike && en;
        end
    end

    always_ff @(posedge clk) begin
        if (strike && en) begin
            cap.tone.octave <= octave;
            cap.tone.note   <= key_note;
            cap.tone.length <= key_length;
            cap.stamp       <= tick;  // Reaction time reference
        end
    end

endmodule

// ==== verilog/hit_scorer.sv ====
module hit_scorer import game_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic                  done,
    input  hit_t                  cap,
    input  tone_t                 goal,
    input  logic [TICK_BITS-1:0]  goal_stamp,
    output grade_t                grade,
    output logic                  grade_valid,
    output logic [SCORE_BITS-1:0] score,
    output logic [COMBO_BITS-1:0] combo
);

    logic [TICK_BITS-1:0]  wait_ticks;
    grade_t                next_grade;
    logic [COMBO_BITS-1:0] next_combo;
    logic [SCORE_BITS-1:0] points;

    // ########################################################################
    // Grading rule
    // ########################################################################

    assign wait_ticks = cap.stamp - goal_stamp;

    always_comb begin
        if (cap.tone.note != goal.note || cap.tone.octave != goal.octave) begin
            next_grade = GRADE_MISS;
        end else if (cap.tone.length != goal.length) begin
            next_grade = GRADE_GOOD;
        end else if (wait_ticks < TICK_BITS'(REACT_FAST)) begin
            next_grade = GRADE_PERFECT;
        end else begin
            next_grade = GRADE_GOOD;
        end
    end

    always_comb begin
        if (next_grade == GRADE_MISS) begin
            next_combo = '0;  // Streak broken
        end else if (combo == '1) begin
            next_combo = combo;
        end else begin
            next_combo = combo + COMBO_BITS'(1);
        end
    end

    // Grade points plus the new combo as bonus
    always_comb begin
        case (next_grade)
            GRADE_PERFECT: points = SCORE_BITS'(POINTS_PERFECT) + SCORE_BITS'(next_combo);
            GRADE_GOOD:    points = SCORE_BITS'(POINTS_GOOD) + SCORE_BITS'(next_combo);
            default:       points = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grade       <= GRADE_MISS;
            grade_valid <= 1'b0;
            score       <= '0;
            combo       <= '0;
        end else begin
            grade_valid <= done && en;
            if (!en) begin
                score <= '0;
                combo <= '0;
            end else if (done) begin
                grade <= next_grade;
                combo <= next_combo;
                score <= score + points;
            end
        end
    end

endmodule

// ==== verilog/play_mode.sv ====
module play_mode import game_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [SONG_BITS-1:0]   song,
    input  logic [NOTE_KEYS-1:0]   note_key,
    input  logic [LENGTH_KEYS-1:0] length_key,
    input  logic                   oct_up,
    input  logic                   oct_down,
    input  logic                   hit,
    output logic [NOTE_KEYS-1:0]   note_led,
    output logic                   buzzer,
    output logic [SCORE_BITS-1:0]  score,
    output logic [COMBO_BITS-1:0]  combo,
    output grade_t                 grade,
    output logic                   grade_valid,
    output logic                   song_done
);

    logic [TICK_BITS-1:0] tick;
    logic [TICK_BITS-1:0] goal_stamp;
    logic [SONG_BITS-1:0] song_sel;
    logic [STEP_BITS-1:0] step;
    logic                 strike;
    hit_t                 cap;
    logic                 cap_valid;
    logic                 busy;
    logic                 done;
    tone_t                goal;
    logic                 last_step;

    // ########################################################################
    // Tick and step sequencing
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= '0;
        end else if (!en) begin
            tick <= '0;
        end else begin
            tick <= tick + TICK_BITS'(1);
        end
    end

    // Song select follows the input until the game starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            song_sel <= '0;
        end else if (!en) begin
            song_sel <= song;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= '0;
            goal_stamp <= '0;
            song_done  <= 1'b0;
        end else begin
            song_done <= 1'b0;
            if (!en) begin
                step       <= '0;
                goal_stamp <= '0;
            end else if (done) begin
                goal_stamp <= tick;  // Next goal shown from now
                if (last_step) begin
                    step      <= '0;
                    song_done <= 1'b1;
                end else begin
                    step <= step + STEP_BITS'(1);
                end
            end
        end
    end

    // One tone at a time
    assign strike = hit && en && !busy;

    hit_capture hit_capture_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .oct_up     (oct_up),
        .oct_down   (oct_down),
        .note_key   (note_key),
        .length_key (length_key),
        .strike     (strike),
        .tick       (tick),
        .cap        (cap),
        .cap_valid  (cap_valid)
    );

    tone_player tone_player_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (cap_valid),
        .tone   (cap.tone),
        .buzzer (buzzer),
        .busy   (busy),
        .done   (done)
    );

    song_rom song_rom_i (
        .song_sel  (song_sel),
        .step      (step),
        .goal      (goal),
        .last_step (last_step)
    );

    hit_scorer hit_scorer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .done        (done),
        .cap         (cap),
        .goal        (goal),
        .goal_stamp  (goal_stamp),
        .grade       (grade),
        .grade_valid (grade_valid),
        .score       (score),
        .combo       (combo)
    );

    // Goal note LED, dark for a rest
    always_comb begin
        for (int i = 0; i < NOTE_KEYS; i++) begin
            note_led[i] = (goal.note == note_t'(i + 1));
        end
    end

endmodule

// ==== verilog/song_rom.sv ====
module song_rom import game_pkg::*; (
    input  logic [SONG_BITS-1:0] song_sel,
    input  logic [STEP_BITS-1:0] step,
    output tone_t                goal,
    output logic                 last_step
);

    always_comb begin
        if (song_sel == '0) begin
            // Song 0 has eight steps
            last_step = (step == STEP_BITS'(7));
            case (step)
                4'd0: goal = '{OCT_MID, NOTE_C, LEN_QUARTER};
                4'd1: goal = '{OCT_MID, NOTE_D, LEN_EIGHTH};
                4'd2: goal = '{OCT_MID, NOTE_E, LEN_QUARTER};
                4'd3: goal = '{OCT_MID, NOTE_C, LEN_EIGHTH};
                4'd4: goal = '{OCT_LOW, NOTE_G, LEN_QUARTER};
                4'd5: goal = '{OCT_MID, NOTE_F, LEN_EIGHTH};
                4'd6: goal = '{OCT_HIGH, NOTE_C, LEN_QUARTER};
                4'd7: goal = '{OCT_MID, NOTE_G, LEN_HALF};
                default: goal = '{OCT_MID, NOTE_REST, LEN_EIGHTH};
            endcase
        end else begin
            // Song 1 has six steps and a rest
            last_step = (step == STEP_BITS'(5));
            case (step)
                4'd0: goal = '{OCT_LOW, NOTE_A, LEN_EIGHTH};
                4'd1: goal = '{OCT_MID, NOTE_B, LEN_QUARTER};
                4'd2: goal = '{OCT_MID, NOTE_REST, LEN_EIGHTH};
                4'd3: goal = '{OCT_HIGH, NOTE_E, LEN_EIGHTH};
                4'd4: goal = '{OCT_HIGH, NOTE_D, LEN_QUARTER};
                4'd5: goal = '{OCT_MID, NOTE_A, LEN_WHOLE};
                default: goal = '{OCT_MID, NOTE_REST, LEN_EIGHTH};
            endcase
        end
    end

endmodule

// ==== verilog/tone_player.sv ====
module tone_player import game_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  tone_t tone,
    output logic  buzzer,
    output logic  busy,
    output logic  done
);

    logic                 active;
    logic [DUR_BITS-1:0]  remain;      // Cycles left after the start cycle
    logic [HALF_BITS-1:0] half;
    logic [HALF_BITS-1:0] phase;
    logic [HALF_BITS-1:0] start_half;
    logic [DUR_BITS-1:0]  start_dur;

    assign start_half = tone_half_period(tone.octave, tone.note);
    assign start_dur  = DUR_BITS'(BEAT_CYCLES) << tone.length;

    // Start cycle already counts toward the length
    assign busy = start || active;
    assign done = active && (remain == DUR_BITS'(1));

    // ########################################################################
    // Duration and square wave
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            remain <= '0;
            half   <= '0;
            phase  <= '0;
            buzzer <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
            remain <= start_dur - DUR_BITS'(1);
            half   <= start_half;
            phase  <= '0;
            buzzer <= (start_half != '0);  // Rest stays silent
        end else if (active) begin
            remain <= remain - DUR_BITS'(1);
            if (done) begin
                active <= 1'b0;
                buzzer <= 1'b0;
            end else if (half != '0) begin
                if (phase == half - HALF_BITS'(1)) begin
                    phase  <= '0;
                    buzzer <= !buzzer;  // Edge every half-period
                end else begin
                    phase <= phase + HALF_BITS'(1);
                end
            end
        end
    end

endmodule

// ==== vlog.f ====
verilog/game_pkg.sv
verilog/hit_capture.sv
verilog/tone_player.sv
verilog/song_rom.sv
verilog/hit_scorer.sv
verilog/play_mode.sv
verification/play_mode_tb.sv
